// File: project.f
design/edge_pkg.sv
design/pixel_fifo.sv
design/grayscale.sv
design/sobel.sv
design/edge_top.sv
sim/edge_tb.sv

// File: Makefile
TOP := edge_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/edge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module edge_tb;

    import edge_pkg::*;

    localparam int frame_count      = 3;
    localparam int total_pixels     = frame_count * pixel_count;
    localparam int timeout_cycles   = frame_count * pixel_count * 10 + 2000;
    localparam int read_hold_cycles = 300;
    localparam int drain_cycles     = 40;
    localparam logic [31:0] seed    = 32'd97112;

    logic                  clock;
    logic                  reset;
    logic                  in_wr_en;
    logic [rgb_width-1:0]  in_din;
    logic                  in_full;
    logic                  out_rd_en;
    logic [gray_width-1:0] out_dout;
    logic                  out_empty;

    // Frames in send order, and the model's edge values in the same order
    logic [rgb_width-1:0]  frame_rgb [total_pixels];
    logic [gray_width-1:0] expected_mem [total_pixels];
    int                    gray_frame [img_height][img_width];

    int                    expected_count;
    int                    read_idx;
    int                    write_idx;
    int                    cycle_count;
    int                    error_count;
    logic [31:0]           rng;
    logic                  saw_out_full;
    logic                  saw_in_full;
    logic                  timed_out;
    logic [gray_width-1:0] expected_head;
    logic                  head_border;

    edge_top uut (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Mean of the three channels, truncated
    function automatic logic [gray_width-1:0] luma(input logic [rgb_width-1:0] rgb);
        int sum;
        sum = int'(rgb[23:16]) + int'(rgb[15:8]) + int'(rgb[7:0]);
        return gray_width'(sum / 3);
    endfunction

    function automatic logic is_border(input int idx);
        int pos;
        int row;
        int col;
        pos = idx % pixel_count;
        row = pos / img_width;
        col = pos % img_width;
        return (row == 0) || (row == img_height - 1) || (col == 0) || (col == img_width - 1);
    endfunction

    function automatic int at(input int r, input int c);
        return gray_frame[r][c];
    endfunction

    task automatic build_frames();
        int col;
        for (int i = 0; i < pixel_count; i++) begin
            // Uniform grey
            frame_rgb[i] = 24'h506070;
            // Random colours
            rng = xorshift32(rng);
            frame_rgb[pixel_count + i] = rng[23:0];
            // Black and white vertical stripes, two pixels wide
            col = i % img_width;
            frame_rgb[2 * pixel_count + i] = ((col / 2) % 2 == 1) ? 24'hffffff : 24'h000000;
        end
    endtask

    task automatic compute_expected();
        int gx;
        int gy;
        int mag;
        int idx;
        for (int f = 0; f < frame_count; f++) begin
            for (int r = 0; r < img_height; r++) begin
                for (int c = 0; c < img_width; c++) begin
                    gray_frame[r][c] = int'(luma(frame_rgb[f * pixel_count + r * img_width + c]));
                end
            end
            for (int r = 0; r < img_height; r++) begin
                for (int c = 0; c < img_width; c++) begin
                    idx = f * pixel_count + r * img_width + c;
                    if (r == 0 || r == img_height - 1 || c == 0 || c == img_width - 1) begin
                        expected_mem[idx] = '0;
                    end else begin
                        // Right column minus left column, bottom row minus top row
                        gx = at(r - 1, c + 1) + 2 * at(r, c + 1) + at(r + 1, c + 1)
                           - at(r - 1, c - 1) - 2 * at(r, c - 1) - at(r + 1, c - 1);
                        gy = at(r + 1, c - 1) + 2 * at(r + 1, c) + at(r + 1, c + 1)
                           - at(r - 1, c - 1) - 2 * at(r - 1, c) - at(r - 1, c + 1);
                        if (gx < 0) begin
                            gx = -gx;
                        end
                        if (gy < 0) begin
                            gy = -gy;
                        end
                        mag = (gx + gy) / 2;
                        expected_mem[idx] = (mag > 255) ? 8'hff : gray_width'(mag);
                    end
                end
            end
        end
        expected_count = total_pixels;
    endtask

    task automatic drive_inputs();
        // Writer leaves random gaps and never writes into a full FIFO
        rng = xorshift32(rng);
        if (write_idx < total_pixels && !in_full && rng[1:0] != 2'b00) begin
            in_wr_en  = 1'b1;
            in_din    = frame_rgb[write_idx];
            write_idx = write_idx + 1;
        end else begin
            in_wr_en = 1'b0;
        end
        // Reader holds off at first so the output FIFO fills, then stalls at random
        rng = xorshift32(rng);
        if (!out_empty && cycle_count >= read_hold_cycles && rng[3:2] != 2'b00) begin
            out_rd_en = 1'b1;
        end else begin
            out_rd_en = 1'b0;
        end
    endtask

    always_comb begin
        if (read_idx < expected_count) begin
            expected_head = expected_mem[read_idx];
        end else begin
            expected_head = '0;
        end
    end

    assign head_border = is_border(read_idx);

    always @(posedge clock) begin
        if (reset) begin
            read_idx     <= 0;
            saw_out_full <= 1'b0;
            saw_in_full  <= 1'b0;
        end else begin
            if (out_rd_en && !out_empty) begin
                read_idx <= read_idx + 1;
            end
            if (uut.edge_full) begin
                saw_out_full <= 1'b1;
            end
            if (in_full) begin
                saw_in_full <= 1'b1;
            end
        end
    end

    output_matches_model: assert property (
        @(posedge clock) disable iff (reset)
        (out_rd_en && !out_empty && read_idx < expected_count) |-> (out_dout == expected_head)
    ) else begin
        error_count++;
        $display("ERROR: out_dout = %h, expected %h at output %0d",
                 $sampled(out_dout), $sampled(expected_head), $sampled(read_idx));
    end

    border_reads_zero: assert property (
        @(posedge clock) disable iff (reset)
        (out_rd_en && !out_empty && head_border) |-> (out_dout == '0)
    ) else begin
        error_count++;
        $display("ERROR: out_dout = %h at a border pixel, expected %h", $sampled(out_dout), 8'h00);
    end

    no_unexpected_output: assert property (
        @(posedge clock) disable iff (reset)
        (out_rd_en && !out_empty) |-> (read_idx < expected_count)
    ) else begin
        error_count++;
        $display("Output produced with nothing left to expect");
    end

    initial begin
        reset          = 1'b1;
        in_wr_en       = 1'b0;
        in_din         = '0;
        out_rd_en      = 1'b0;
        error_count    = 0;
        write_idx      = 0;
        cycle_count    = 0;
        expected_count = 0;
        timed_out      = 1'b0;
        rng            = seed;
        build_frames();
        compute_expected();

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Both ends idle out of reset
        assert (in_full == 1'b0) else begin
            error_count++;
            $display("ERROR: in_full = %h, expected %h", in_full, 1'b0);
        end
        assert (out_empty == 1'b1) else begin
            error_count++;
            $display("ERROR: out_empty = %h, expected %h", out_empty, 1'b1);
        end

        // All three frames go in back to back
        while (read_idx < total_pixels && !timed_out) begin
            @(negedge clock);
            drive_inputs();
            cycle_count++;
            if (cycle_count >= timeout_cycles) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            error_count++;
            $display("Timeout reached after %0d cycles with %0d of %0d outputs read",
                     cycle_count, read_idx, total_pixels);
        end else begin
            // Keep reading a while to catch any extra output
            repeat (drain_cycles) begin
                @(negedge clock);
                drive_inputs();
            end
            assert (read_idx == total_pixels) else begin
                error_count++;
                $display("ERROR: read_idx = %h, expected %h", read_idx, total_pixels);
            end
            assert (out_empty) else begin
                error_count++;
                $display("Output FIFO still holds data after the last expected value");
            end
            assert (saw_out_full) else begin
                error_count++;
                $display("Output FIFO never filled, so back-pressure was not exercised");
            end
            assert (saw_in_full) else begin
                error_count++;
                $display("Input FIFO never reported full while the pipeline was held");
            end
        end

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/edge_top.sv
`timescale 1ns/1ps
`default_nettype none

module edge_top (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            in_wr_en,
    input  logic [edge_pkg::rgb_width-1:0]  in_din,
    output logic                            in_full,
    input  logic                            out_rd_en,
    output logic [edge_pkg::gray_width-1:0] out_dout,
    output logic                            out_empty
);

    import edge_pkg::*;

    // Input FIFO to grayscale
    logic                  rgb_rd_en;
    logic                  rgb_empty;
    logic [rgb_width-1:0]  rgb_dout;

    // Grayscale to middle FIFO, and middle FIFO to Sobel
    logic                  gray_wr_en;
    logic                  gray_full;
    logic [gray_width-1:0] gray_din;
    logic                  gray_rd_en;
    logic                  gray_empty;
    logic [gray_width-1:0] gray_dout;

    // Sobel to output FIFO
    logic                  edge_wr_en;
    logic                  edge_full;
    logic [gray_width-1:0] edge_din;

    pixel_fifo #(
        .data_width (rgb_width),
        .depth      (in_fifo_depth)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (rgb_rd_en),
        .dout  (rgb_dout),
        .empty (rgb_empty)
    );

    grayscale gray (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (rgb_rd_en),
        .in_empty  (rgb_empty),
        .in_dout   (rgb_dout),
        .out_wr_en (gray_wr_en),
        .out_full  (gray_full),
        .out_din   (gray_din)
    );

    pixel_fifo #(
        .data_width (gray_width),
        .depth      (mid_fifo_depth)
    ) mid_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (gray_wr_en),
        .din   (gray_din),
        .full  (gray_full),
        .rd_en (gray_rd_en),
        .dout  (gray_dout),
        .empty (gray_empty)
    );

    sobel filter (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (gray_rd_en),
        .in_empty  (gray_empty),
        .in_dout   (gray_dout),
        .out_wr_en (edge_wr_en),
        .out_full  (edge_full),
        .out_din   (edge_din)
    );

    pixel_fifo #(
        .data_width (gray_width),
        .depth      (out_fifo_depth)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (edge_wr_en),
        .din   (edge_din),
        .full  (edge_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

`default_nettype wire

// File: design/sobel.sv
`timescale 1ns/1ps
`default_nettype none

module sobel (
    input  logic                            clock,
    input  logic                            reset,
    output logic                            in_rd_en,
    input  logic                            in_empty,
    input  logic [edge_pkg::gray_width-1:0] in_dout,
    output logic                            out_wr_en,
    input  logic                            out_full,
    output logic [edge_pkg::gray_width-1:0] out_din
);

    import edge_pkg::*;

    logic [state_width-1:0] state;
    logic [state_width-1:0] next_state;

    // Index 0 holds the newest pixel, line_len-1 the oldest
    logic [line_len-1:0][gray_width-1:0] line_buf;
    logic [line_len-1:0][gray_width-1:0] line_buf_c;

    logic [pro_width-1:0] pro_cnt;
    logic [pro_width-1:0] pro_cnt_c;
    logic [col_width-1:0] col;
    logic [col_width-1:0] col_c;
    logic [row_width-1:0] row;
    logic [row_width-1:0] row_c;

    // Registered gradient magnitudes
    logic [grad_width-1:0] cx;
    logic [grad_width-1:0] cx_c;
    logic [grad_width-1:0] cy;
    logic [grad_width-1:0] cy_c;

    // Window taps around the centre pixel
    logic [gray_width-1:0] nw, nn, ne;
    logic [gray_width-1:0] ww, ee;
    logic [gray_width-1:0] sw, ss, se;

    logic [grad_width-1:0] gx_pos, gx_neg, gy_pos, gy_neg;
    logic [grad_width-1:0] abs_x, abs_y;
    logic [grad_width:0]   grad_sum;
    logic [grad_width-1:0] grad_half;

    logic [idx_width-1:0] pixel_idx;
    logic                 pad_zone;
    logic                 last_pixel;
    logic                 border;

    assign nw = line_buf[line_len - 1];
    assign nn = line_buf[line_len - 2];
    assign ne = line_buf[line_len - 3];
    assign ww = line_buf[img_width + 2];
    assign ee = line_buf[img_width];
    assign sw = line_buf[2];
    assign ss = line_buf[1];
    assign se = line_buf[0];

    // Positive and negative halves kept apart, so no signed math is needed
    assign gx_pos = grad_width'(ne) + (grad_width'(ee) << 1) + grad_width'(se);
    assign gx_neg = grad_width'(nw) + (grad_width'(ww) << 1) + grad_width'(sw);
    assign gy_pos = grad_width'(sw) + (grad_width'(ss) << 1) + grad_width'(se);
    assign gy_neg = grad_width'(nw) + (grad_width'(nn) << 1) + grad_width'(ne);

    assign abs_x = (gx_pos >= gx_neg) ? gx_pos - gx_neg : gx_neg - gx_pos;
    assign abs_y = (gy_pos >= gy_neg) ? gy_pos - gy_neg : gy_neg - gy_pos;

    // Half the gradient sum, saturated to one byte
    assign grad_sum  = {1'b0, cx} + {1'b0, cy};
    assign grad_half = grad_sum[grad_width:1];
    assign out_din   = (|grad_half[grad_width-1:gray_width]) ? '1 : grad_half[gray_width-1:0];

    assign pixel_idx  = idx_width'(row * img_width + col);
    assign pad_zone   = (pixel_idx >= idx_width'(pad_start));
    assign last_pixel = (row == row_width'(img_height - 1)) && (col == col_width'(img_width - 1));
    assign border     = (row == '0) || (row == row_width'(img_height - 1)) ||
                        (col == '0) || (col == col_width'(img_width - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= st_prologue;
            pro_cnt <= '0;
            col     <= '0;
            row     <= '0;
        end else begin
            state   <= next_state;
            pro_cnt <= pro_cnt_c;
            col     <= col_c;
            row     <= row_c;
        end
    end

    always_ff @(posedge clock) begin
        line_buf <= line_buf_c;
        cx       <= cx_c;
        cy       <= cy_c;
    end

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        line_buf_c = line_buf;
        pro_cnt_c  = pro_cnt;
        col_c      = col;
        row_c      = row;
        cx_c       = cx;
        cy_c       = cy;

        case (state)
            st_prologue: begin
                // Fill until the first centre pixel has its lower neighbours
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    line_buf_c = {line_buf[line_len-2:0], in_dout};
                    pro_cnt_c  = pro_cnt + 1'b1;
                    if (pro_cnt == pro_width'(img_width + 1)) begin
                        next_state = st_filter;
                    end
                end
            end
            st_filter: begin
                // Window is ready; proceed only if the next value can be shifted in
                if (last_pixel || pad_zone || !in_empty) begin
                    if (!last_pixel) begin
                        if (pad_zone) begin
                            // Past the frame end, the FIFO head belongs to the next frame
                            line_buf_c = {line_buf[line_len-2:0], {gray_width{1'b0}}};
                        end else begin
                            in_rd_en   = 1'b1;
                            line_buf_c = {line_buf[line_len-2:0], in_dout};
                        end
                    end
                    if (border) begin
                        cx_c = '0;
                        cy_c = '0;
                    end else begin
                        cx_c = abs_x;
                        cy_c = abs_y;
                    end
                    if (col == col_width'(img_width - 1)) begin
                        col_c = '0;
                        row_c = last_pixel ? '0 : row + 1'b1;
                    end else begin
                        col_c = col + 1'b1;
                    end
                    next_state = st_output;
                end
            end
            st_output: begin
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    // Position wrapped to zero means the whole frame is out
                    if (row == '0 && col == '0) begin
                        pro_cnt_c  = '0;
                        next_state = st_prologue;
                    end else begin
                        next_state = st_filter;
                    end
                end
            end
            default: begin
                next_state = st_prologue;
            end
        endcase
    end

    no_write_when_full: assert property (
        @(posedge clock) disable iff (reset) out_wr_en |-> !out_full
    ) else $error("sobel write while output full");

    position_in_range: assert property (
        @(posedge clock) disable iff (reset)
        (int'(col) < img_width) && (int'(row) < img_height)
    ) else $error("sobel position counter out of range");

endmodule

`default_nettype wire

// File: design/grayscale.sv
`timescale 1ns/1ps
`default_nettype none

module grayscale (
    input  logic                          clock,
    input  logic                          reset,
    output logic                          in_rd_en,
    input  logic                          in_empty,
    input  logic [edge_pkg::rgb_width-1:0] in_dout,
    output logic                          out_wr_en,
    input  logic                          out_full,
    output logic [edge_pkg::gray_width-1:0] out_din
);

    import edge_pkg::*;

    logic [gray_width-1:0] red;
    logic [gray_width-1:0] green;
    logic [gray_width-1:0] blue;
    logic [gray_width+1:0] sum;
    logic                  move;

    // Red in the top byte, blue in the bottom byte
    assign {red, green, blue} = in_dout;

    assign sum = (gray_width + 2)'(red) + (gray_width + 2)'(green) + (gray_width + 2)'(blue);

    // Mean of three channels, truncated; never exceeds 255
    assign out_din = gray_width'(sum / 3);

    // One pixel moves whenever there is data and room
    assign move      = !in_empty && !out_full;
    assign in_rd_en  = move;
    assign out_wr_en = move;

    no_push_when_full: assert property (
        @(posedge clock) disable iff (reset) out_wr_en |-> !out_full
    ) else $error("grayscale push while output full");

endmodule

`default_nettype wire

// File: design/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    parameter int data_width = 8,
    parameter int depth      = 16
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [data_width-1:0] din,
    output logic                  full,
    input  logic                  rd_en,
    output logic [data_width-1:0] dout,
    output logic                  empty
);

    localparam int addr_width = $clog2(depth);
    localparam int cnt_width  = $clog2(depth + 1);

    logic [data_width-1:0] mem [depth];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [cnt_width-1:0]  count;
    logic                  do_write;
    logic                  do_read;

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign full  = (count == cnt_width'(depth));
    assign empty = (count == '0);

    // Show-ahead: the head entry is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == addr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == addr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producers and consumers must respect the flags
    no_write_when_full: assert property (
        @(posedge clock) disable iff (reset) wr_en |-> !full
    ) else $error("pixel_fifo write while full");

    no_read_when_empty: assert property (
        @(posedge clock) disable iff (reset) rd_en |-> !empty
    ) else $error("pixel_fifo read while empty");

endmodule

`default_nettype wire

// File: design/edge_pkg.sv
`default_nettype none

package edge_pkg;

    // Image geometry
    localparam int img_width   = 16;
    localparam int img_height  = 12;
    localparam int pixel_count = img_width * img_height;

    // Sobel line buffer holds two rows plus three pixels
    localparam int line_len = 2 * img_width + 3;

    // Pixel word widths
    localparam int rgb_width  = 24;
    localparam int gray_width = 8;

    // FIFO depths along the chain
    localparam int in_fifo_depth  = 16;
    localparam int mid_fifo_depth = 16;
    localparam int out_fifo_depth = 32;

    // Counter widths used by the Sobel stage
    localparam int col_width = $clog2(img_width);
    localparam int row_width = $clog2(img_height);
    localparam int pro_width = $clog2(img_width + 3);
    localparam int idx_width = $clog2(pixel_count);

    // From this pixel index on, the next shifted value lies past the frame
    localparam int pad_start = pixel_count - (img_width + 2);

    // Gradient magnitude reaches 4 * 255, so two extra bits
    localparam int grad_width = gray_width + 2;

    // Sobel FSM encoding
    localparam int state_width = 2;
    localparam logic [state_width-1:0] st_prologue = 2'd0;
    localparam logic [state_width-1:0] st_filter   = 2'd1;
    localparam logic [state_width-1:0] st_output   = 2'd2;

endpackage

`default_nettype wire
